/* rtl/dconv_pkg.sv */
`default_nettype none

package dconv_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data widths

	parameter int PIXEL_W  = 8;
	parameter int WEIGHT_W = 8;
	// Nine 16-bit products need four extra bits
	parameter int ACC_W    = 20;

	typedef logic signed [PIXEL_W-1:0]           pixel_t;
	typedef logic signed [WEIGHT_W-1:0]          weight_t;
	typedef logic signed [PIXEL_W+WEIGHT_W-1:0]  prod_t;
	typedef logic signed [ACC_W-1:0]             acc_t;

	//////////////////////////////////////////////////////////////////////
	// 3x3 window and kernel, first digit is row, second is column

	typedef struct packed {
		pixel_t tap_00;
		pixel_t tap_01;
		pixel_t tap_02;
		pixel_t tap_10;
		pixel_t tap_11;
		pixel_t tap_12;
		pixel_t tap_20;
		pixel_t tap_21;
		pixel_t tap_22;
	} window_t;

	typedef struct packed {
		weight_t tap_00;
		weight_t tap_01;
		weight_t tap_02;
		weight_t tap_10;
		weight_t tap_11;
		weight_t tap_12;
		weight_t tap_20;
		weight_t tap_21;
		weight_t tap_22;
	} kernel_t;

endpackage

`default_nettype wire

/* rtl/tap_delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

module tap_delay_line
	import dconv_pkg::*;
#(
	parameter int DEPTH = 2
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   shift,
	input  pixel_t din,
	output pixel_t dout
);

	pixel_t stages [DEPTH];

	// Moves one place per accepted pixel, holds otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				stages[i] <= '0;
			end
		end else if (shift) begin
			stages[0] <= din;
			for (int i = 1; i < DEPTH; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	// Oldest entry is DEPTH pixels behind din
	assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

/* rtl/dilated_window_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module dilated_window_buffer
	import dconv_pkg::*;
#(
	parameter int IMAGE_WIDTH  = 12,
	parameter int IMAGE_HEIGHT = 12,
	parameter int RATE         = 2
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pix_valid,
	input  pixel_t  pix_data,
	output logic    pix_ready,
	input  logic    stride2,
	output logic    win_valid,
	output window_t win,
	input  logic    win_ready
);

	localparam int COL_W   = $clog2(IMAGE_WIDTH);
	localparam int ROW_W   = $clog2(IMAGE_HEIGHT);
	// Distance from the left tap of one kernel row to the right tap of the row above
	localparam int ROW_GAP = RATE*IMAGE_WIDTH - 2*RATE;

	logic             accept;
	logic             keep;
	logic             stride_ok;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	logic [COL_W-1:0] col_off;
	logic [ROW_W-1:0] row_off;

	// chain[0] is the newest pixel, chain[8] the oldest tap
	pixel_t chain [9];

	//////////////////////////////////////////////////////////////////////
	// Handshake

	assign pix_ready = !win_valid || win_ready;
	assign accept    = pix_valid && pix_ready;

	//////////////////////////////////////////////////////////////////////
	// Dilated tap chain
	// Order along the chain: 22 21 20 12 11 10 02 01 00

	assign chain[0] = pix_data;

	genvar i;
	generate
		for (i = 0; i < 8; i++) begin : g_taps
			// Every third gap jumps back one dilated row
			localparam int DEPTH = (i % 3 == 2) ? ROW_GAP : RATE;

			tap_delay_line #(
				.DEPTH(DEPTH)
			) tap_delay_line_inst (
				.clk  (clk),
				.reset(reset),
				.shift(accept),
				.din  (chain[i]),
				.dout (chain[i+1])
			);
		end
	endgenerate

	//////////////////////////////////////////////////////////////////////
	// Position of the newest pixel

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			if (col == COL_W'(IMAGE_WIDTH - 1)) begin
				col <= '0;
				if (row == ROW_W'(IMAGE_HEIGHT - 1)) begin
					row <= '0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Offsets from the first full window of the frame
	assign col_off = col - COL_W'(2*RATE);
	assign row_off = row - ROW_W'(2*RATE);

	// Stride2 keeps even offsets in both directions
	assign stride_ok = !stride2 || (!col_off[0] && !row_off[0]);

	// Whole window inside the image, wrap-around windows are dropped
	assign keep = (col >= COL_W'(2*RATE)) && (row >= ROW_W'(2*RATE)) && stride_ok;

	//////////////////////////////////////////////////////////////////////
	// Window register

	always_ff @(posedge clk) begin
		if (reset) begin
			win_valid <= 1'b0;
		end else if (accept) begin
			win_valid <= keep;
		end else if (win_ready) begin
			win_valid <= 1'b0;
		end
	end

	// Taps are sampled before this edge's shift, together with the new pixel
	always_ff @(posedge clk) begin
		if (accept) begin
			win.tap_22 <= chain[0];
			win.tap_21 <= chain[1];
			win.tap_20 <= chain[2];
			win.tap_12 <= chain[3];
			win.tap_11 <= chain[4];
			win.tap_10 <= chain[5];
			win.tap_02 <= chain[6];
			win.tap_01 <= chain[7];
			win.tap_00 <= chain[8];
		end
	end

endmodule

`default_nettype wire

/* rtl/weight_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module weight_regs
	import dconv_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    w_valid,
	input  weight_t w_data,
	output kernel_t kernel
);

	logic [3:0]    idx;
	// Element 8 is tap_00, element 0 is tap_22
	weight_t [8:0] regs;

	// Serial load in row-major order
	always_ff @(posedge clk) begin
		if (reset) begin
			idx  <= '0;
			regs <= '0;
		end else if (w_valid) begin
			regs[4'd8 - idx] <= w_data;
			if (idx == 4'd8) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	assign kernel = regs;

endmodule

`default_nettype wire

/* rtl/window_mac.sv */
`timescale 1ns/100ps
`default_nettype none

module window_mac
	import dconv_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    win_valid,
	input  window_t win,
	output logic    win_ready,
	input  kernel_t kernel,
	output logic    res_valid,
	output acc_t    res_data,
	input  logic    res_ready
);

	// Flat views, same element order for pixels and weights
	pixel_t  [8:0] taps;
	weight_t [8:0] wts;

	prod_t   [8:0] prod;
	logic          prod_valid;
	logic          prod_ready;

	acc_t    [8:0] ext;
	acc_t          sum_a;
	acc_t          sum_b;
	acc_t          sum_c;
	acc_t          sum_d;
	acc_t          sum_ab;
	acc_t          sum_cde;
	acc_t          sum;

	assign taps = win;
	assign wts  = kernel;

	// Backward ready chain
	assign prod_ready = !res_valid || res_ready;
	assign win_ready  = !prod_valid || prod_ready;

	//////////////////////////////////////////////////////////////////////
	// Stage one, nine signed products

	always_ff @(posedge clk) begin
		if (reset) begin
			prod_valid <= 1'b0;
		end else if (win_ready) begin
			prod_valid <= win_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid && win_ready) begin
			for (int i = 0; i < 9; i++) begin
				prod[i] <= taps[i] * wts[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage two, adder tree

	always_comb begin
		for (int i = 0; i < 9; i++) begin
			ext[i] = acc_t'(prod[i]);
		end
	end

	assign sum_a   = ext[0] + ext[1];
	assign sum_b   = ext[2] + ext[3];
	assign sum_c   = ext[4] + ext[5];
	assign sum_d   = ext[6] + ext[7];
	assign sum_ab  = sum_a + sum_b;
	// Odd ninth term joins here
	assign sum_cde = sum_c + sum_d + ext[8];
	assign sum     = sum_ab + sum_cde;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
		end else if (prod_ready) begin
			res_valid <= prod_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid && prod_ready) begin
			res_data <= sum;
		end
	end

endmodule

`default_nettype wire

/* rtl/dilated_conv_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dilated_conv_top
	import dconv_pkg::*;
#(
	parameter int IMAGE_WIDTH  = 12,
	parameter int IMAGE_HEIGHT = 12,
	parameter int RATE         = 2
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    pix_valid,
	input  pixel_t  pix_data,
	output logic    pix_ready,
	input  logic    stride2,
	input  logic    w_valid,
	input  weight_t w_data,
	output logic    res_valid,
	output acc_t    res_data,
	input  logic    res_ready
);

	logic    win_valid;
	logic    win_ready;
	window_t win;
	kernel_t kernel;

	//////////////////////////////////////////////////////////////////////
	// Pixel stream to windows

	dilated_window_buffer #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT),
		.RATE        (RATE)
	) dilated_window_buffer_inst (
		.clk      (clk),
		.reset    (reset),
		.pix_valid(pix_valid),
		.pix_data (pix_data),
		.pix_ready(pix_ready),
		.stride2  (stride2),
		.win_valid(win_valid),
		.win      (win),
		.win_ready(win_ready)
	);

	weight_regs weight_regs_inst (
		.clk    (clk),
		.reset  (reset),
		.w_valid(w_valid),
		.w_data (w_data),
		.kernel (kernel)
	);

	//////////////////////////////////////////////////////////////////////
	// Windows to sums

	window_mac window_mac_inst (
		.clk      (clk),
		.reset    (reset),
		.win_valid(win_valid),
		.win      (win),
		.win_ready(win_ready),
		.kernel   (kernel),
		.res_valid(res_valid),
		.res_data (res_data),
		.res_ready(res_ready)
	);

endmodule

`default_nettype wire

/* sim/dilated_conv_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dilated_conv_tb
	import dconv_pkg::*;
();

	localparam int IMAGE_WIDTH    = 12;
	localparam int IMAGE_HEIGHT   = 12;
	localparam int RATE           = 2;
	localparam int FRAME_PIXELS   = IMAGE_WIDTH*IMAGE_HEIGHT;
	// Eight frames over all tests
	localparam int TOTAL_PIXELS   = 8*FRAME_PIXELS;
	localparam int TIMEOUT_CYCLES = 8*TOTAL_PIXELS + 2000;
	localparam int DRAIN_LIMIT    = 500;
	localparam logic [31:0] POLY  = 32'h80200003;

	logic    clk = 1'b0;
	logic    reset;
	logic    pix_valid;
	pixel_t  pix_data;
	logic    pix_ready;
	logic    stride2;
	logic    w_valid;
	weight_t w_data;
	logic    res_valid;
	acc_t    res_data;
	logic    res_ready;

	logic [31:0] lfsr_state = 32'hb29d;
	logic        rand_ready = 1'b0;
	pixel_t      img [FRAME_PIXELS];
	weight_t     kern [9];
	int          exp_q [$];
	int          err_count = 0;
	int          errs_at_start = 0;
	int          res_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	int          cycle_count = 0;

	dilated_conv_top #(
		.IMAGE_WIDTH (IMAGE_WIDTH),
		.IMAGE_HEIGHT(IMAGE_HEIGHT),
		.RATE        (RATE)
	) dilated_conv_top_inst (
		.clk      (clk),
		.reset    (reset),
		.pix_valid(pix_valid),
		.pix_data (pix_data),
		.pix_ready(pix_ready),
		.stride2  (stride2),
		.w_valid  (w_valid),
		.w_data   (w_data),
		.res_valid(res_valid),
		.res_data (res_data),
		.res_ready(res_ready)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Random source and reference model

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ POLY) : (lfsr_state >> 1);
		end
		return r;
	endfunction

	// Dilated 3x3 sum around one center of the current image
	function automatic int ref_sum(input int cy, input int cx, input int rate);
		int acc;
		int py;
		int px;
		acc = 0;
		for (int ky = 0; ky < 3; ky++) begin
			for (int kx = 0; kx < 3; kx++) begin
				py  = cy + (ky - 1)*rate;
				px  = cx + (kx - 1)*rate;
				acc += int'(img[py*IMAGE_WIDTH + px]) * int'(kern[ky*3 + kx]);
			end
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected 0x%h got 0x%h", name, expected, actual);
			err_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Scoreboard, compares each accepted result with the queue head

	always @(posedge clk) begin
		if (!reset && res_valid && res_ready) begin
			res_count++;
			if (exp_q.size() == 0) begin
				$display("A result arrived when none was expected");
				err_count++;
			end else begin
				check_value("res_data", exp_q.pop_front(), res_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic drive_ready();
		res_ready = rand_ready ? (rand_bits(1) != 0) : 1'b1;
	endtask

	task automatic load_kernel();
		for (int k = 0; k < 9; k++) begin
			@(negedge clk);
			w_valid = 1'b1;
			w_data  = kern[k];
		end
		@(negedge clk);
		w_valid = 1'b0;
	endtask

	task automatic fill_random_image();
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			img[i] = pixel_t'(rand_bits(8));
		end
	endtask

	task automatic fill_const_image(input pixel_t v);
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			img[i] = v;
		end
	endtask

	// Kept centers in raster order
	task automatic queue_expected(input bit s2, input bit use_fixed, input int fixed_val);
		for (int cy = RATE; cy < IMAGE_HEIGHT - RATE; cy++) begin
			for (int cx = RATE; cx < IMAGE_WIDTH - RATE; cx++) begin
				if (!s2 || (((cy - RATE) % 2 == 0) && ((cx - RATE) % 2 == 0))) begin
					exp_q.push_back(use_fixed ? fixed_val : ref_sum(cy, cx, RATE));
				end
			end
		end
	endtask

	task automatic send_frame(input bit gaps);
		int  n;
		logic busy;
		n    = 0;
		busy = 1'b0;
		while (n < FRAME_PIXELS) begin
			@(negedge clk);
			drive_ready();
			if (!busy) begin
				// Roughly one bubble in four when gaps are on
				if (gaps && rand_bits(2) == 0) begin
					pix_valid = 1'b0;
				end else begin
					pix_valid = 1'b1;
					pix_data  = img[n];
					busy      = 1'b1;
				end
			end
			@(posedge clk);
			if (pix_valid && pix_ready) begin
				n++;
				busy = 1'b0;
			end
		end
		@(negedge clk);
		pix_valid = 1'b0;
		drive_ready();
	endtask

	task automatic drain_results();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			drive_ready();
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d results were missing at the end of the frame", exp_q.size());
			err_count++;
			exp_q.delete();
		end
		// Room for any extra result to show up
		repeat (8) begin
			@(negedge clk);
			drive_ready();
		end
	endtask

	task automatic run_frame(input bit s2, input bit gaps, input bit rnd_ready,
			input bit use_fixed, input int fixed_val, input int n_expected);
		int count_start;
		@(negedge clk);
		stride2    = s2;
		rand_ready = rnd_ready;
		queue_expected(s2, use_fixed, fixed_val);
		count_start = res_count;
		send_frame(gaps);
		drain_results();
		check_value("result count", n_expected, res_count - count_start);
		rand_ready = 1'b0;
		res_ready  = 1'b1;
	endtask

	task automatic start_test();
		errs_at_start = err_count;
	endtask

	task automatic end_test(input string name);
		if (err_count == errs_at_start) begin
			$display("Test %s passed", name);
			pass_count++;
		end else begin
			$display("Test %s failed with %0d errors", name, err_count - errs_at_start);
			fail_count++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		reset     = 1'b1;
		pix_valid = 1'b0;
		pix_data  = '0;
		stride2   = 1'b0;
		w_valid   = 1'b0;
		w_data    = '0;
		res_ready = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		start_test();
		repeat (5) begin
			@(negedge clk);
			check_value("res_valid", 32'd0, res_valid);
			check_value("pix_ready", 32'd1, pix_ready);
		end
		end_test("idle after reset");

		start_test();
		for (int k = 0; k < 9; k++) kern[k] = weight_t'(rand_bits(8));
		load_kernel();
		fill_random_image();
		run_frame(1'b0, 1'b0, 1'b0, 1'b0, 0, 64);
		end_test("dense frame");

		start_test();
		fill_random_image();
		run_frame(1'b1, 1'b0, 1'b0, 1'b0, 0, 16);
		end_test("stride2 frame");

		start_test();
		fill_random_image();
		run_frame(1'b0, 1'b1, 1'b1, 1'b0, 0, 64);
		fill_random_image();
		run_frame(1'b1, 1'b1, 1'b1, 1'b0, 0, 16);
		end_test("back-pressure and gaps");

		start_test();
		fill_random_image();
		run_frame(1'b0, 1'b0, 1'b0, 1'b0, 0, 64);
		// New kernel once the first frame has left the MAC
		for (int k = 0; k < 9; k++) kern[k] = weight_t'(rand_bits(8));
		load_kernel();
		fill_random_image();
		run_frame(1'b0, 1'b0, 1'b0, 1'b0, 0, 64);
		end_test("weight reload");

		start_test();
		for (int k = 0; k < 9; k++) kern[k] = -8'sd128;
		load_kernel();
		fill_const_image(-8'sd128);
		run_frame(1'b0, 1'b0, 1'b0, 1'b1, 147456, 64);
		fill_const_image(8'sd127);
		run_frame(1'b0, 1'b0, 1'b0, 1'b1, -146304, 64);
		end_test("extreme values");

		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
rtl/dconv_pkg.sv
rtl/tap_delay_line.sv
rtl/dilated_window_buffer.sv
rtl/weight_regs.sv
rtl/window_mac.sv
rtl/dilated_conv_top.sv
sim/dilated_conv_tb.sv

/* Bender.yml */
package:
  name: dilated_conv

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - rtl/dconv_pkg.sv
      - rtl/tap_delay_line.sv
      - rtl/dilated_window_buffer.sv
      - rtl/weight_regs.sv
      - rtl/window_mac.sv
      - rtl/dilated_conv_top.sv

  - target: simulation
    files:
      - sim/dilated_conv_tb.sv
